//--- sa_pkg.sv
package sa_pkg;

  ////////////////////////////////////////
  // precision modes
  typedef enum logic {
    MODE_8X8 = 1'b0,  // two 8x8 products per cycle
    MODE_4X4 = 1'b1   // four 4x4 products per cycle
  } mode_e;

  // multiplier ports, sized like the 25x18 DSP
  localparam int OPA_W  = 25;
  localparam int OPB_W  = 18;
  localparam int PROD_W = OPA_W + OPB_W;  // 43
  localparam int OPER_W = 25;             // operand word in the mesh

  localparam int LANE88_W = 24;
  localparam int LANE44_W = 16;
  localparam int ACC_W    = 64;

  // where the narrow products sit inside the wide one
  localparam int SPLIT88 = 16;  // lane boundary, 8x8
  localparam int FIELD44 = 9;   // field pitch, 4x4

  localparam int DRAIN_ROWS = 2;  // rows carried by one drain word

  ////////////////////////////////////////
  // accumulator word, two ways of reading it
  typedef struct packed {
    logic [ACC_W-2*LANE88_W-1:0] pad;
    logic [LANE88_W-1:0]         lane1;
    logic [LANE88_W-1:0]         lane0;
  } acc88_t;

  typedef union packed {
    acc88_t                   m88;
    logic [3:0][LANE44_W-1:0] m44;  // lane 0 in the low bits
  } acc_u;

  ////////////////////////////////////////
  // edge and drain transfers
  typedef struct packed {
    logic              valid;
    logic [OPER_W-1:0] word;
  } edge_t;

  typedef struct packed {
    logic [7:0]            col;  // column being shifted out
    acc_u [DRAIN_ROWS-1:0] acc;
  } drain_t;

endpackage

//--- packed_mult.sv
`timescale 1ns/1ns

module packed_mult
  import sa_pkg::*;
#(
  parameter int MULT_STAGES = 2
) (
  input  logic                     clk,
  input  logic signed [OPA_W-1:0]  a,
  input  logic signed [OPB_W-1:0]  b,
  output logic signed [PROD_W-1:0] p
);

  logic signed [OPA_W-1:0]  a_q;
  logic signed [OPB_W-1:0]  b_q;
  logic signed [PROD_W-1:0] pipe [MULT_STAGES-1];  // product stages after the input regs

  // input regs plus at least one product reg, as in the DSP slice
  if (MULT_STAGES < 2) begin : g_bad_stages
    $error("packed_mult needs MULT_STAGES of 2 or more");
  end

  always_ff @(posedge clk) begin
    a_q     <= a;
    b_q     <= b;
    pipe[0] <= a_q * b_q;  // full signed 43-bit product
    for (int i = 1; i < MULT_STAGES - 1; i++) begin
      pipe[i] <= pipe[i-1];
    end
  end

  assign p = pipe[MULT_STAGES-2];

endmodule

//--- pe_cell.sv
`timescale 1ns/1ns

module pe_cell
  import sa_pkg::*;
#(
  parameter int MULT_STAGES = 2
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              acc_en,
  input  logic              shift_en,
  input  mode_e             mode,
  input  logic [OPER_W-1:0] left,
  input  logic [OPER_W-1:0] up,
  output logic [OPER_W-1:0] right,
  output logic [OPER_W-1:0] bottom,
  input  acc_u              drain_in,
  output acc_u              acc
);

  logic signed [OPA_W-1:0]  mult_a;
  logic signed [OPB_W-1:0]  mult_b;
  logic signed [PROD_W-1:0] prod;
  logic [LANE88_W-1:0]      d88 [2];  // lane increments, 8x8
  logic [LANE44_W-1:0]      d44 [4];  // lane increments, 4x4
  acc_u                     acc_nxt;

  ////////////////////////////////////////
  // operand forwarding
  always_ff @(posedge clk) begin
    if (reset) begin
      right  <= '0;
      bottom <= '0;
    end else if (acc_en) begin
      right  <= left;
      bottom <= up;
    end
  end

  // 8x8: pixel pair on the wide port
  // 4x4: weight pair on the wide port
  assign mult_a = (mode == MODE_8X8) ? up : left;
  assign mult_b = (mode == MODE_8X8) ? left[OPB_W-1:0] : up[OPB_W-1:0];

  packed_mult #(
    .MULT_STAGES(MULT_STAGES)
  ) i_mult (
    .clk(clk),
    .a  (mult_a),
    .b  (mult_b),
    .p  (prod)
  );

  ////////////////////////////////////////
  // lane split
  // a negative lower field borrows one from the field above, so each
  // upper field gets the sign of the field below added back
  always_comb begin
    d88[0] = {{(LANE88_W-SPLIT88){prod[SPLIT88-1]}}, prod[SPLIT88-1:0]};
    d88[1] = {{(LANE88_W-SPLIT88){prod[2*SPLIT88-1]}}, prod[2*SPLIT88-1:SPLIT88]}
             + LANE88_W'(prod[SPLIT88-1]);

    d44[0] = {{(LANE44_W-FIELD44){prod[FIELD44-1]}}, prod[FIELD44-1:0]};
    for (int k = 1; k < 4; k++) begin
      d44[k] = {{(LANE44_W-FIELD44){prod[FIELD44*k+FIELD44-1]}}, prod[FIELD44*k +: FIELD44]}
               + LANE44_W'(prod[FIELD44*k-1]);
    end
  end

  // lanes wrap at their own width
  always_comb begin
    acc_nxt = acc;
    if (mode == MODE_8X8) begin
      acc_nxt.m88.lane0 = acc.m88.lane0 + d88[0];
      acc_nxt.m88.lane1 = acc.m88.lane1 + d88[1];
    end else begin
      for (int k = 0; k < 4; k++) begin
        acc_nxt.m44[k] = acc.m44[k] + d44[k];
      end
    end
  end

  ////////////////////////////////////////
  // accumulator and drain stage
  always_ff @(posedge clk) begin
    if (reset) begin
      acc <= '0;
    end else if (shift_en) begin
      acc <= drain_in;  // take the right neighbour's word
    end else if (acc_en) begin
      acc <= acc_nxt;
    end
  end

  // the sequencer keeps accumulate and drain apart
  a_acc_shift_excl: assert property (@(posedge clk) disable iff (reset)
    !(acc_en && shift_en))
    else $error("pe_cell: acc_en and shift_en high together");

endmodule

//--- pe_array.sv
`timescale 1ns/1ns

module pe_array
  import sa_pkg::*;
#(
  parameter int ROWS        = 2,
  parameter int COLS        = 3,
  parameter int MULT_STAGES = 2
) (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        acc_en,
  input  logic                        shift_en,
  input  mode_e                       mode,
  input  logic [ROWS-1:0][OPER_W-1:0] left_edge,
  input  logic [COLS-1:0][OPER_W-1:0] top_edge,
  output acc_u [ROWS-1:0]             col0_acc
);

  logic [OPER_W-1:0] h_bus [ROWS][COLS+1];  // left to right
  logic [OPER_W-1:0] v_bus [ROWS+1][COLS];  // top to bottom
  acc_u              d_bus [ROWS][COLS+1];  // drain, right to left

  ////////////////////////////////////////
  // edges
  for (genvar r = 0; r < ROWS; r++) begin : g_row_edge
    assign h_bus[r][0]    = left_edge[r];
    assign d_bus[r][COLS] = '0;  // zeros follow the drain in
    assign col0_acc[r]    = d_bus[r][0];
  end

  for (genvar c = 0; c < COLS; c++) begin : g_col_edge
    assign v_bus[0][c] = top_edge[c];
  end

  ////////////////////////////////////////
  // cell grid
  for (genvar r = 0; r < ROWS; r++) begin : g_row
    for (genvar c = 0; c < COLS; c++) begin : g_col
      pe_cell #(
        .MULT_STAGES(MULT_STAGES)
      ) i_cell (
        .clk     (clk),
        .reset   (reset),
        .acc_en  (acc_en),
        .shift_en(shift_en),
        .mode    (mode),
        .left    (h_bus[r][c]),
        .up      (v_bus[r][c]),
        .right   (h_bus[r][c+1]),
        .bottom  (v_bus[r+1][c]),
        .drain_in(d_bus[r][c+1]),
        .acc     (d_bus[r][c])
      );
    end
  end

endmodule

//--- operand_skew.sv
`timescale 1ns/1ns

module operand_skew
  import sa_pkg::*;
#(
  parameter int ROWS = 2,
  parameter int COLS = 3
) (
  input  logic                        clk,
  input  logic                        reset,
  input  edge_t [ROWS-1:0]            left_in,
  input  edge_t [COLS-1:0]            up_in,
  output logic [ROWS-1:0][OPER_W-1:0] left_edge,
  output logic [COLS-1:0][OPER_W-1:0] top_edge
);

  localparam int LANES = ROWS + COLS;

  edge_t [LANES-1:0]             lane_in;
  logic  [LANES-1:0][OPER_W-1:0] lane_out;

  assign lane_in   = {up_in, left_in};  // rows low, columns high
  assign left_edge = lane_out[ROWS-1:0];
  assign top_edge  = lane_out[LANES-1:ROWS];

  ////////////////////////////////////////
  // delay lines
  // one common register so the first word meets acc_en,
  // then r or c more stages for the diagonal wavefront
  for (genvar i = 0; i < LANES; i++) begin : g_lane
    localparam int DEPTH = (i < ROWS) ? i + 1 : i - ROWS + 1;

    edge_t sr [DEPTH];

    always_ff @(posedge clk) begin
      if (reset) begin
        for (int k = 0; k < DEPTH; k++) begin
          sr[k] <= '0;
        end
      end else begin
        sr[0] <= lane_in[i];
        for (int k = 1; k < DEPTH; k++) begin
          sr[k] <= sr[k-1];
        end
      end
    end

    assign lane_out[i] = sr[DEPTH-1].valid ? sr[DEPTH-1].word : '0;  // gaps add nothing
  end

endmodule

//--- array_sequencer.sv
`timescale 1ns/1ns

module array_sequencer
  import sa_pkg::*;
#(
  parameter int ROWS        = 2,
  parameter int COLS        = 3,
  parameter int MULT_STAGES = 2
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       in_valid,
  input  logic       in_last,
  input  mode_e      mode,
  input  logic       drain,
  output logic       acc_en,
  output logic       shift_en,
  output mode_e      cell_mode,
  output logic       out_valid,
  output logic [7:0] out_col
);

  // last word crosses the skew and the grid, then the multiplier
  localparam int FLUSH = ROWS + COLS + MULT_STAGES;
  localparam int FW    = $clog2(FLUSH + 1);

  localparam logic [1:0] S_IDLE  = 2'd0;
  localparam logic [1:0] S_ACC   = 2'd1;
  localparam logic [1:0] S_DRAIN = 2'd2;

  logic [1:0]    state;
  logic          last_seen;  // in_last taken, flushing
  logic [FW-1:0] flush_cnt;
  logic [7:0]    col_cnt;

  ////////////////////////////////////////
  // burst / drain FSM
  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= S_IDLE;
      cell_mode <= MODE_8X8;
      last_seen <= 1'b0;
      flush_cnt <= '0;
      col_cnt   <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (in_valid) begin
            state     <= S_ACC;
            cell_mode <= mode;  // held for the whole burst
            last_seen <= in_last;
            flush_cnt <= FW'(FLUSH);
          end else if (drain) begin
            state   <= S_DRAIN;
            col_cnt <= '0;
          end
        end
        S_ACC: begin
          if (in_valid) begin
            last_seen <= in_last;  // a new burst restarts the flush
            flush_cnt <= FW'(FLUSH);
          end else if (last_seen) begin
            if (flush_cnt == FW'(1)) begin
              state <= S_IDLE;
            end else begin
              flush_cnt <= flush_cnt - 1'b1;
            end
          end
        end
        S_DRAIN: begin
          if (col_cnt == 8'(COLS - 1)) begin
            state <= S_IDLE;
          end else begin
            col_cnt <= col_cnt + 1'b1;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  assign acc_en    = (state == S_ACC);
  assign shift_en  = (state == S_DRAIN);
  assign out_valid = shift_en;  // col 0 holds column col_cnt
  assign out_col   = col_cnt;

  ////////////////////////////////////////
  // protocol checks
  a_no_input_in_drain: assert property (@(posedge clk) disable iff (reset)
    state == S_DRAIN |-> !in_valid)
    else $error("array_sequencer: in_valid during drain");

  a_drain_accepted: assert property (@(posedge clk) disable iff (reset)
    drain |-> state == S_IDLE && !in_valid)
    else $error("array_sequencer: drain strobe ignored, array busy");

endmodule

//--- systolic_top.sv
`timescale 1ns/1ns

module systolic_top
  import sa_pkg::*;
#(
  parameter int ROWS        = 2,
  parameter int COLS        = 3,
  parameter int MULT_STAGES = 2
) (
  input  logic             clk,
  input  logic             reset,
  input  logic             in_valid,
  input  logic             in_last,
  input  mode_e            mode,
  input  edge_t [ROWS-1:0] left_in,
  input  edge_t [COLS-1:0] up_in,
  input  logic             drain,
  output logic             out_valid,
  output drain_t           out
);

  logic [ROWS-1:0][OPER_W-1:0] left_edge;
  logic [COLS-1:0][OPER_W-1:0] top_edge;
  logic                        acc_en;
  logic                        shift_en;
  mode_e                       cell_mode;
  logic [7:0]                  out_col;
  acc_u [ROWS-1:0]             col0_acc;

  // drain word is sized in the package
  if (ROWS != DRAIN_ROWS) begin : g_bad_rows
    $error("systolic_top: ROWS must equal DRAIN_ROWS");
  end

  operand_skew #(
    .ROWS(ROWS),
    .COLS(COLS)
  ) i_skew (
    .clk      (clk),
    .reset    (reset),
    .left_in  (left_in),
    .up_in    (up_in),
    .left_edge(left_edge),
    .top_edge (top_edge)
  );

  array_sequencer #(
    .ROWS       (ROWS),
    .COLS       (COLS),
    .MULT_STAGES(MULT_STAGES)
  ) i_seq (
    .clk      (clk),
    .reset    (reset),
    .in_valid (in_valid),
    .in_last  (in_last),
    .mode     (mode),
    .drain    (drain),
    .acc_en   (acc_en),
    .shift_en (shift_en),
    .cell_mode(cell_mode),
    .out_valid(out_valid),
    .out_col  (out_col)
  );

  pe_array #(
    .ROWS       (ROWS),
    .COLS       (COLS),
    .MULT_STAGES(MULT_STAGES)
  ) i_array (
    .clk      (clk),
    .reset    (reset),
    .acc_en   (acc_en),
    .shift_en (shift_en),
    .mode     (cell_mode),
    .left_edge(left_edge),
    .top_edge (top_edge),
    .col0_acc (col0_acc)
  );

  assign out.col = out_col;
  assign out.acc = col0_acc;  // one word per row

endmodule

//--- tb_systolic_top.sv
`timescale 1ns/1ns

module tb_systolic_top
  import sa_pkg::*;
();

  localparam int ROWS        = 2;
  localparam int COLS        = 3;
  localparam int MULT_STAGES = 2;
  localparam int PERIOD      = 8;
  localparam int FLUSH       = ROWS + COLS + MULT_STAGES;

  // burst lengths that also size the watchdog
  localparam int LEN_RAND = 24;
  localparam int LEN_WRAP = 1100;  // enough to wrap both lane widths
  localparam int LEN_GAP  = 16;
  localparam int BEATS    = 4 * LEN_RAND + 2 * LEN_WRAP + 3 * LEN_GAP;
  localparam int WATCHDOG = 10 + 2 * BEATS + 8 * (FLUSH + 4) + 9 * (COLS + 12);

  logic             clk = 1'b0;
  logic             reset;
  logic             in_valid;
  logic             in_last;
  mode_e            mode;
  edge_t [ROWS-1:0] left_in;
  edge_t [COLS-1:0] up_in;
  logic             drain;
  logic             out_valid;
  drain_t           out;

  acc_u        exp_acc [ROWS][COLS];  // reference accumulators
  mode_e       exp_mode = MODE_8X8;
  logic [31:0] rng_state = 32'h25d7;

  systolic_top #(
    .ROWS       (ROWS),
    .COLS       (COLS),
    .MULT_STAGES(MULT_STAGES)
  ) i_dut (
    .clk      (clk),
    .reset    (reset),
    .in_valid (in_valid),
    .in_last  (in_last),
    .mode     (mode),
    .left_in  (left_in),
    .up_in    (up_in),
    .drain    (drain),
    .out_valid(out_valid),
    .out      (out)
  );

  always #(PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////
  // helpers
  function automatic int rand_signed(input int bits);
    int v;
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    v = int'(rng_state & ((32'd1 << bits) - 1));
    if (v >= (1 << (bits - 1))) begin
      v = v - (1 << bits);  // two's complement of the low bits
    end
    return v;
  endfunction

  task automatic stop_with_failure();
    $display("TEST FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_acc(input acc_u got, input acc_u exp, input string name);
    int          lanes;
    logic [31:0] g;
    logic [31:0] e;
    lanes = (exp_mode == MODE_8X8) ? 2 : 4;
    for (int k = 0; k < lanes; k++) begin
      if (exp_mode == MODE_8X8) begin
        g = (k == 0) ? 32'(got.m88.lane0) : 32'(got.m88.lane1);
        e = (k == 0) ? 32'(exp.m88.lane0) : 32'(exp.m88.lane1);
      end else begin
        g = 32'(got.m44[k]);
        e = 32'(exp.m44[k]);
      end
      if (g !== e) begin
        $display("ERROR %0t %s lane %0d: got %h, expected %h", $time, name, k, g, e);
        stop_with_failure();
      end
    end
  endtask

  task automatic check_col(input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("ERROR %0t out.col: got %0d, expected %0d", $time, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string name);
    if (got !== exp) begin
      $display("ERROR %0t %s: got %b, expected %b", $time, name, got, exp);
      stop_with_failure();
    end
  endtask

  ////////////////////////////////////////
  // stimulus
  task automatic send_beat(input edge_t [ROWS-1:0] lw, input edge_t [COLS-1:0] uw,
                           input mode_e m, input bit last, input bit gap_after);
    @(posedge clk);
    in_valid <= 1'b1;
    in_last  <= last;
    mode     <= m;
    left_in  <= lw;
    up_in    <= uw;
    if (gap_after && !last) begin
      @(posedge clk);
      in_valid <= 1'b0;  // stale words with valid low must add nothing
      for (int r = 0; r < ROWS; r++) begin
        left_in[r].valid <= 1'b0;
      end
      for (int c = 0; c < COLS; c++) begin
        up_in[c].valid <= 1'b0;
      end
    end
  endtask

  task automatic end_burst();
    @(posedge clk);
    in_valid <= 1'b0;
    in_last  <= 1'b0;
    left_in  <= '0;
    up_in    <= '0;
    repeat (FLUSH + 1) @(posedge clk);  // sequencer back in idle
  endtask

  // ROWS weights and COLS pixel pairs per beat
  task automatic burst_8x8(input int w[$], input int px[$], input bit gaps);
    int               n;
    int               p0;
    int               p1;
    edge_t [ROWS-1:0] lw;
    edge_t [COLS-1:0] uw;
    n = w.size() / ROWS;
    exp_mode = MODE_8X8;
    for (int t = 0; t < n; t++) begin
      for (int r = 0; r < ROWS; r++) begin
        lw[r] = '{valid: 1'b1, word: OPER_W'(w[t*ROWS+r])};
      end
      for (int c = 0; c < COLS; c++) begin
        p0 = px[(t*COLS+c)*2];
        p1 = px[(t*COLS+c)*2+1];
        uw[c] = '{valid: 1'b1, word: OPER_W'(p0 + p1 * 65536)};
        for (int r = 0; r < ROWS; r++) begin
          exp_acc[r][c].m88.lane0 = exp_acc[r][c].m88.lane0 + LANE88_W'(w[t*ROWS+r] * p0);
          exp_acc[r][c].m88.lane1 = exp_acc[r][c].m88.lane1 + LANE88_W'(w[t*ROWS+r] * p1);
        end
      end
      send_beat(lw, uw, MODE_8X8, t == n - 1, gaps && (t % 2 == 1));
    end
    end_burst();
  endtask

  // weight pairs per row in a, value pairs per column in b
  task automatic burst_4x4(input int a[$], input int b[$]);
    int               n;
    int               a0;
    int               a1;
    int               b0;
    int               b1;
    edge_t [ROWS-1:0] lw;
    edge_t [COLS-1:0] uw;
    n = a.size() / (ROWS * 2);
    exp_mode = MODE_4X4;
    for (int t = 0; t < n; t++) begin
      for (int r = 0; r < ROWS; r++) begin
        a0 = a[(t*ROWS+r)*2];
        a1 = a[(t*ROWS+r)*2+1];
        lw[r] = '{valid: 1'b1, word: OPER_W'(a0 + a1 * 262144)};
        for (int c = 0; c < COLS; c++) begin
          b0 = b[(t*COLS+c)*2];
          b1 = b[(t*COLS+c)*2+1];
          uw[c] = '{valid: 1'b1, word: OPER_W'(b0 + b1 * 512)};
          exp_acc[r][c].m44[0] = exp_acc[r][c].m44[0] + LANE44_W'(a0 * b0);
          exp_acc[r][c].m44[1] = exp_acc[r][c].m44[1] + LANE44_W'(a0 * b1);
          exp_acc[r][c].m44[2] = exp_acc[r][c].m44[2] + LANE44_W'(a1 * b0);
          exp_acc[r][c].m44[3] = exp_acc[r][c].m44[3] + LANE44_W'(a1 * b1);
        end
      end
      send_beat(lw, uw, MODE_4X4, t == n - 1, 1'b0);
    end
    end_burst();
  endtask

  task automatic do_drain();
    int waited;
    @(posedge clk);
    drain <= 1'b1;
    @(posedge clk);
    drain  <= 1'b0;
    waited = 0;
    @(negedge clk);
    while (!out_valid) begin
      if (waited == 10) begin
        $display("out_valid never rose after the drain strobe");
        stop_with_failure();
      end
      waited++;
      @(negedge clk);
    end
    for (int k = 0; k < COLS; k++) begin
      check_flag(out_valid, 1'b1, "out_valid");
      check_col(out.col, 8'(k));
      for (int r = 0; r < ROWS; r++) begin
        check_acc(out.acc[r], exp_acc[r][k], $sformatf("out.acc[%0d] col %0d", r, k));
      end
      @(negedge clk);
    end
    check_flag(out_valid, 1'b0, "out_valid");  // exactly COLS cycles
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        exp_acc[r][c] = '0;  // drain clears the array
      end
    end
  endtask

  ////////////////////////////////////////
  // run
  initial begin
    int w[$];
    int px[$];
    int a[$];
    int b[$];
    reset    = 1'b1;
    in_valid = 1'b0;
    in_last  = 1'b0;
    mode     = MODE_8X8;
    left_in  = '0;
    up_in    = '0;
    drain    = 1'b0;
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        exp_acc[r][c] = '0;
      end
    end
    repeat (10) @(posedge clk);
    reset <= 1'b0;

    do_drain();  // empty array reads zero

    // signed bytes with -128 and negative pairs up front
    for (int i = 0; i < LEN_RAND * ROWS; i++) begin
      w.push_back(rand_signed(8));
    end
    for (int i = 0; i < LEN_RAND * COLS * 2; i++) begin
      px.push_back(rand_signed(8));
    end
    w[0]  = -128;
    w[1]  = 127;  // positive weight makes lane 0 negative, lane 1 borrows
    px[0] = -128;
    px[1] = -1;
    px[2] = -1;
    px[3] = -128;
    burst_8x8(w, px, 1'b0);
    do_drain();

    // signed nibbles with an all-negative first beat
    for (int i = 0; i < LEN_RAND * ROWS * 2; i++) begin
      a.push_back(i < ROWS * 2 ? -8 : rand_signed(4));
    end
    for (int i = 0; i < LEN_RAND * COLS * 2; i++) begin
      b.push_back(i < COLS * 2 ? -1 : rand_signed(4));
    end
    burst_4x4(a, b);
    do_drain();

    // two bursts into one drain and a drain of the cleared array
    burst_8x8(w, px, 1'b0);
    burst_8x8(w, px, 1'b0);
    do_drain();
    do_drain();

    // lane wrap
    w  = {};
    px = {};
    a  = {};
    b  = {};
    for (int i = 0; i < LEN_WRAP * ROWS; i++) begin
      w.push_back(-128);
    end
    for (int i = 0; i < LEN_WRAP * COLS * 2; i++) begin
      px.push_back(-128);
    end
    for (int i = 0; i < LEN_WRAP * ROWS * 2; i++) begin
      a.push_back(-8);
    end
    for (int i = 0; i < LEN_WRAP * COLS * 2; i++) begin
      b.push_back(-8);
    end
    burst_8x8(w, px, 1'b0);
    do_drain();
    burst_4x4(a, b);
    do_drain();

    // gapped and back-to-back versions of the same data
    w  = {};
    px = {};
    for (int i = 0; i < LEN_GAP * ROWS; i++) begin
      w.push_back(rand_signed(8));
    end
    for (int i = 0; i < LEN_GAP * COLS * 2; i++) begin
      px.push_back(rand_signed(8));
    end
    burst_8x8(w, px, 1'b1);
    do_drain();
    burst_8x8(w, px, 1'b0);
    do_drain();

    $display("TEST PASS");
    $finish;
  end

  initial begin
    #(WATCHDOG * PERIOD);
    $display("watchdog expired before the tests finished");
    stop_with_failure();
  end

endmodule

//--- filelist.f
sa_pkg.sv
packed_mult.sv
pe_cell.sv
pe_array.sv
operand_skew.sv
array_sequencer.sv
systolic_top.sv
tb_systolic_top.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_systolic_top \
  -f filelist.f -o tb_systolic_top
./obj_dir/tb_systolic_top
